// File: files.f
rtl/dispatch_pkg.sv
rtl/route_table.sv
rtl/sample_fifo.sv
rtl/instr_dispatcher.sv
rtl/instr_output.sv
rtl/pid_dispatch_top.sv
sim/pid_dispatch_sva.sv
sim/pid_dispatch_tb.sv

// File: rtl/dispatch_pkg.sv
package dispatch_pkg;

   // ------------------------------
   // Index widths
   // ------------------------------

   // Source tag width, up to 32 sources
   localparam int SRC_IDX_W = 5;

   // Output channel index width, up to 32 channels
   localparam int CHAN_IDX_W = 5;

   // ------------------------------
   // Configuration registers
   // ------------------------------

   localparam int CFG_ADDR_W = 4;

   // Per-channel enable
   localparam logic [CFG_ADDR_W-1:0] CFG_ADDR_ENABLE = 4'h0;

   // Per-channel source select
   localparam logic [CFG_ADDR_W-1:0] CFG_ADDR_ROUTE = 4'h1;

   // Bit positions inside the data word
   localparam int CFG_EN_BIT = 0;
   localparam int CFG_NULL_BIT = SRC_IDX_W;

   // ------------------------------
   // Configuration data word
   // ------------------------------

   // Enable view: bits 7..1 unused, bit 0 enable
   // Route view: bits 7..6 unused, bit 5 null flag, bits 4..0 source
   typedef union packed {
      logic [7:0] en_view;
      logic [7:0] route_view;
   } cfg_word_u;

endpackage

// File: rtl/instr_dispatcher.sv
module instr_dispatcher #(
   parameter int N_CHAN = 8,
   parameter int DATA_W = 18
) (
   input  logic                                clk_in,
   input  logic                                reset,
   input  logic                                head_valid,
   input  logic [dispatch_pkg::SRC_IDX_W-1:0]  head_src,
   input  logic [DATA_W-1:0]                   head_data,
   input  logic [N_CHAN-1:0]                   active_mask,
   input  logic                                credit_ok,
   output logic                                pop,
   output logic                                issue,
   output logic [dispatch_pkg::CHAN_IDX_W-1:0] issue_chan,
   output logic [DATA_W-1:0]                   issue_data
);

   // ------------------------------
   // Walk state
   // ------------------------------

   // Channels already issued for the head sample
   logic [N_CHAN-1:0] sent;

   // Source of the sample being walked
   logic [dispatch_pkg::SRC_IDX_W-1:0] walk_src;

   logic [N_CHAN-1:0] sent_live;
   logic [N_CHAN-1:0] remaining;
   logic [N_CHAN-1:0] pick_bit;
   logic              any_left;
   logic              last_one;

   // Sent bits only count for the source that started the walk
   assign sent_live = (walk_src == head_src) ? sent : '0;

   assign remaining = active_mask & ~sent_live;
   assign any_left = |remaining;

   // Lowest set bit of the remaining mask
   assign pick_bit = remaining & (~remaining + N_CHAN'(1));

   // At most one bit left means this pick finishes the sample
   assign last_one = ((remaining & (remaining - N_CHAN'(1))) == '0);

   // ------------------------------
   // Channel pick
   // ------------------------------

   // Scan down so the lowest channel wins
   always_comb begin
      issue_chan = '0;
      for (int i = N_CHAN - 1; i >= 0; i--) begin
         if (remaining[i]) begin
            issue_chan = dispatch_pkg::CHAN_IDX_W'(i);
         end
      end
   end

   // Nothing goes out without a downstream credit
   assign issue = head_valid && credit_ok && any_left;
   assign issue_data = head_data;

   // Empty mask pops at once, no credit needed
   assign pop = head_valid && (!any_left || (issue && last_one));

   // ------------------------------
   // Sent mask update
   // ------------------------------

   always_ff @(posedge clk_in) begin
      if (reset) begin
         sent <= '0;
         walk_src <= '0;
      end else if (pop) begin
         // Next sample starts with a clean mask
         sent <= '0;
      end else if (issue) begin
         sent <= sent_live | pick_bit;
         walk_src <= head_src;
      end
   end

endmodule

// File: rtl/instr_output.sv
module instr_output #(
   parameter int N_CHAN = 8,
   parameter int DATA_W = 18,
   parameter int OUT_CREDITS = 2
) (
   input  logic                                clk_in,
   input  logic                                reset,
   input  logic                                issue,
   input  logic [dispatch_pkg::CHAN_IDX_W-1:0] issue_chan,
   input  logic [DATA_W-1:0]                   issue_data,
   input  logic                                o_credit,
   output logic                                credit_ok,
   output logic                                dv_out,
   output logic [dispatch_pkg::CHAN_IDX_W-1:0] chan_out,
   output logic [DATA_W-1:0]                   data_out
);

   localparam int CNT_W = $clog2(OUT_CREDITS + 1);
   localparam logic [CNT_W-1:0] CNT_MAX = CNT_W'(OUT_CREDITS);

   // Channels past N_CHAN never reach the outputs
   localparam logic [dispatch_pkg::CHAN_IDX_W:0] CHAN_LIM = (dispatch_pkg::CHAN_IDX_W + 1)'(N_CHAN);

   // ------------------------------
   // Output credits
   // ------------------------------

   logic [CNT_W-1:0] credit_cnt;
   logic             chan_ok;

   assign credit_ok = (credit_cnt != '0);

   always_ff @(posedge clk_in) begin
      if (reset) begin
         credit_cnt <= CNT_MAX;
      end else begin
         case ({issue, o_credit})
            2'b10: credit_cnt <= credit_cnt - 1'b1;
            // Saturate on a stray return
            2'b01: credit_cnt <= (credit_cnt == CNT_MAX) ? CNT_MAX : credit_cnt + 1'b1;
            // Spend and return together leave the count alone
            default: credit_cnt <= credit_cnt;
         endcase
      end
   end

   // ------------------------------
   // Instruction register
   // ------------------------------

   assign chan_ok = ({1'b0, issue_chan} < CHAN_LIM);

   always_ff @(posedge clk_in) begin
      if (reset) begin
         dv_out <= 1'b0;
      end else begin
         dv_out <= issue && chan_ok;
      end
   end

   // Payload holds between instructions
   always_ff @(posedge clk_in) begin
      if (issue) begin
         chan_out <= issue_chan;
         data_out <= issue_data;
      end
   end

endmodule

// File: rtl/pid_dispatch_top.sv
module pid_dispatch_top #(
   parameter int N_SRC = 8,
   parameter int N_CHAN = 8,
   parameter int DATA_W = 18,
   parameter int FIFO_DEPTH = 4,
   parameter int OUT_CREDITS = 2
) (
   input  logic                                clk_in,
   input  logic                                reset,
   // Sample input
   input  logic                                s_valid,
   input  logic [dispatch_pkg::SRC_IDX_W-1:0]  s_src,
   input  logic [DATA_W-1:0]                   s_data,
   output logic                                s_credit,
   // Configuration
   input  logic                                cfg_wr,
   input  logic [dispatch_pkg::CFG_ADDR_W-1:0] cfg_addr,
   input  logic [dispatch_pkg::CHAN_IDX_W-1:0] cfg_chan,
   input  dispatch_pkg::cfg_word_u             cfg_data,
   // Instruction output
   output logic                                dv_out,
   output logic [dispatch_pkg::CHAN_IDX_W-1:0] chan_out,
   output logic [DATA_W-1:0]                   data_out,
   input  logic                                o_credit
);

   // ------------------------------
   // Internal wires
   // ------------------------------

   logic                                head_valid;
   logic [dispatch_pkg::SRC_IDX_W-1:0]  head_src;
   logic [DATA_W-1:0]                   head_data;
   logic                                pop;
   logic [N_CHAN-1:0]                   active_mask;
   logic                                credit_ok;
   logic                                issue;
   logic [dispatch_pkg::CHAN_IDX_W-1:0] issue_chan;
   logic [DATA_W-1:0]                   issue_data;

   // Sample queue
   sample_fifo #(.DATA_W(DATA_W), .FIFO_DEPTH(FIFO_DEPTH)) sample_fifo_inst (
      .clk_in(clk_in), .reset(reset), .s_valid(s_valid), .s_src(s_src), .s_data(s_data),
      .pop(pop), .head_valid(head_valid), .head_src(head_src), .head_data(head_data),
      .s_credit(s_credit));

   // Decode
   route_table #(.N_SRC(N_SRC), .N_CHAN(N_CHAN)) route_table_inst (
      .clk_in(clk_in), .reset(reset), .cfg_wr(cfg_wr), .cfg_addr(cfg_addr),
      .cfg_chan(cfg_chan), .cfg_data(cfg_data), .head_src(head_src),
      .active_mask(active_mask));

   // Execute
   instr_dispatcher #(.N_CHAN(N_CHAN), .DATA_W(DATA_W)) instr_dispatcher_inst (
      .clk_in(clk_in), .reset(reset), .head_valid(head_valid), .head_src(head_src),
      .head_data(head_data), .active_mask(active_mask), .credit_ok(credit_ok),
      .pop(pop), .issue(issue), .issue_chan(issue_chan), .issue_data(issue_data));

   // Result
   instr_output #(.N_CHAN(N_CHAN), .DATA_W(DATA_W), .OUT_CREDITS(OUT_CREDITS))
      instr_output_inst (
      .clk_in(clk_in), .reset(reset), .issue(issue), .issue_chan(issue_chan),
      .issue_data(issue_data), .o_credit(o_credit), .credit_ok(credit_ok),
      .dv_out(dv_out), .chan_out(chan_out), .data_out(data_out));

endmodule

// File: rtl/route_table.sv
module route_table #(
   parameter int N_SRC = 8,
   parameter int N_CHAN = 8
) (
   input  logic                                  clk_in,
   input  logic                                  reset,
   input  logic                                  cfg_wr,
   input  logic [dispatch_pkg::CFG_ADDR_W-1:0]   cfg_addr,
   input  logic [dispatch_pkg::CHAN_IDX_W-1:0]   cfg_chan,
   input  dispatch_pkg::cfg_word_u               cfg_data,
   input  logic [dispatch_pkg::SRC_IDX_W-1:0]    head_src,
   output logic [N_CHAN-1:0]                     active_mask
);

   // Select widths for the local arrays
   localparam int CSEL_W = (N_CHAN > 1) ? $clog2(N_CHAN) : 1;
   localparam int SSEL_W = (N_SRC > 1) ? $clog2(N_SRC) : 1;

   // Stored route entry is the null flag above the source index
   localparam int SEL_W = dispatch_pkg::SRC_IDX_W + 1;
   localparam logic [SEL_W-1:0] NULL_SEL = {1'b1, {(SEL_W - 1){1'b0}}};

   // ------------------------------
   // Configuration state
   // ------------------------------

   logic [N_CHAN-1:0] chan_en;
   logic [SEL_W-1:0]  chan_sel [N_CHAN];

   // One row per source, one bit per channel it drives
   logic [N_CHAN-1:0] src_map [N_SRC];

   // ------------------------------
   // Write decode
   // ------------------------------

   logic              wr_ok;
   logic [CSEL_W-1:0] wr_idx;
   logic [SEL_W-1:0]  new_sel;
   logic              new_live;
   logic [SEL_W-1:0]  old_sel;
   logic              old_live;
   logic              head_ok;

   // Channels at or above N_CHAN are ignored
   assign wr_ok = cfg_wr && (32'(cfg_chan) < N_CHAN);
   assign wr_idx = cfg_chan[CSEL_W-1:0];

   // Route view of the data word
   assign new_sel = cfg_data.route_view[dispatch_pkg::CFG_NULL_BIT:0];

   // Source beyond N_SRC counts as no source
   assign new_live = !new_sel[SEL_W-1] &&
                     (32'(new_sel[SEL_W-2:0]) < N_SRC);

   // Stored entries are always either live or NULL_SEL
   assign old_sel = chan_sel[wr_idx];
   assign old_live = !old_sel[SEL_W-1];

   always_ff @(posedge clk_in) begin
      if (reset) begin
         chan_en <= '0;
         for (int c = 0; c < N_CHAN; c++) begin
            chan_sel[c] <= NULL_SEL;
         end
         for (int s = 0; s < N_SRC; s++) begin
            src_map[s] <= '0;
         end
      end else if (wr_ok) begin
         case (cfg_addr)
            dispatch_pkg::CFG_ADDR_ENABLE: begin
               chan_en[wr_idx] <= cfg_data.en_view[dispatch_pkg::CFG_EN_BIT];
            end
            dispatch_pkg::CFG_ADDR_ROUTE: begin
               chan_sel[wr_idx] <= new_live ? new_sel : NULL_SEL;
               // Drop the channel from its old source row
               if (old_live) begin
                  src_map[old_sel[SSEL_W-1:0]][wr_idx] <= 1'b0;
               end
               // Later assignment wins when old and new source match
               if (new_live) begin
                  src_map[new_sel[SSEL_W-1:0]][wr_idx] <= 1'b1;
               end
            end
            default: begin
               // Unknown addresses change nothing
            end
         endcase
      end
   end

   // ------------------------------
   // Head lookup
   // ------------------------------

   assign head_ok = 32'(head_src) < N_SRC;

   // Combinational so a write is seen one cycle after cfg_wr
   assign active_mask = head_ok ? (src_map[head_src[SSEL_W-1:0]] & chan_en) : '0;

endmodule

// File: rtl/sample_fifo.sv
module sample_fifo #(
   parameter int DATA_W = 18,
   parameter int FIFO_DEPTH = 4
) (
   input  logic                               clk_in,
   input  logic                               reset,
   input  logic                               s_valid,
   input  logic [dispatch_pkg::SRC_IDX_W-1:0] s_src,
   input  logic [DATA_W-1:0]                  s_data,
   input  logic                               pop,
   output logic                               head_valid,
   output logic [dispatch_pkg::SRC_IDX_W-1:0] head_src,
   output logic [DATA_W-1:0]                  head_data,
   output logic                               s_credit
);

   localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
   localparam int CNT_W = $clog2(FIFO_DEPTH + 1);
   localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(FIFO_DEPTH - 1);

   // Storage, tag and data side by side
   logic [dispatch_pkg::SRC_IDX_W-1:0] src_mem [FIFO_DEPTH];
   logic [DATA_W-1:0]                  data_mem [FIFO_DEPTH];

   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [CNT_W-1:0] count;
   logic             full;
   logic             push;
   logic             do_pop;

   assign full = (count == CNT_W'(FIFO_DEPTH));
   assign head_valid = (count != '0);
   assign do_pop = pop && head_valid;

   // Full queue still takes a sample when the head leaves this cycle
   assign push = s_valid && (!full || do_pop);

   assign head_src = src_mem[rd_ptr];
   assign head_data = data_mem[rd_ptr];

   always_ff @(posedge clk_in) begin
      if (push) begin
         src_mem[wr_ptr] <= s_src;
         data_mem[wr_ptr] <= s_data;
      end
   end

   // Pointers wrap at FIFO_DEPTH, which need not be a power of two
   always_ff @(posedge clk_in) begin
      if (reset) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count <= '0;
         s_credit <= 1'b0;
      end else begin
         if (push) begin
            wr_ptr <= (wr_ptr == LAST_PTR) ? '0 : wr_ptr + 1'b1;
         end
         if (do_pop) begin
            rd_ptr <= (rd_ptr == LAST_PTR) ? '0 : rd_ptr + 1'b1;
         end
         count <= count + CNT_W'(push) - CNT_W'(do_pop);
         // One credit back per freed entry
         s_credit <= do_pop;
      end
   end

endmodule

// File: run_sim.sh
#!/bin/bash
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/1ps \
   --top-module pid_dispatch_tb -f files.f \
   || { echo "Build failed"; exit 1; }
./obj_dir/Vpid_dispatch_tb | tee /dev/stderr | grep -qF '** PASS **' \
   && { echo "Simulation passed"; exit 0; } \
   || { echo "Simulation failed"; exit 1; }

// File: sim/pid_dispatch_sva.sv
module pid_dispatch_sva #(
   parameter int N_CHAN = 8,
   parameter int FIFO_DEPTH = 4,
   parameter int OUT_CREDITS = 2
) (
   input logic                                clk_in,
   input logic                                reset,
   input logic                                s_valid,
   input logic                                s_credit,
   input logic                                dv_out,
   input logic [dispatch_pkg::CHAN_IDX_W-1:0] chan_out,
   input logic                                o_credit
);
   timeunit 1ns;
   timeprecision 1ps;

   // Instructions out and not yet retired downstream
   int out_held;

   // Samples sent and not yet credited back
   int in_held;

   always_ff @(posedge clk_in) begin
      if (reset) begin
         out_held <= 0;
         in_held <= 0;
      end else begin
         out_held <= out_held + int'(dv_out) - int'(o_credit);
         in_held <= in_held + int'(s_valid) - int'(s_credit);
      end
   end

   // No instruction goes out once all output credits are spent
   assert property (@(posedge clk_in) disable iff (reset) dv_out |-> (out_held < OUT_CREDITS))
      else $error("dv_out fired with no output credit");

   // Channel index stays inside the configured range
   assert property (@(posedge clk_in) disable iff (reset) dv_out |-> (32'(chan_out) < N_CHAN))
      else $error("chan_out out of range with dv_out high");

   // Input credit only comes back for a sample still held
   assert property (@(posedge clk_in) disable iff (reset) s_credit |-> (in_held > 0))
      else $error("s_credit returned while the queue was empty");

   // A sample without a credit would land in a full queue and be dropped
   assert property (@(posedge clk_in) disable iff (reset) s_valid |-> (in_held < FIFO_DEPTH))
      else $error("sample sent with no input credit");

endmodule

bind pid_dispatch_top pid_dispatch_sva #(
   .N_CHAN(N_CHAN), .FIFO_DEPTH(FIFO_DEPTH), .OUT_CREDITS(OUT_CREDITS)
) pid_dispatch_sva_inst (
   .clk_in(clk_in), .reset(reset), .s_valid(s_valid), .s_credit(s_credit), .dv_out(dv_out),
   .chan_out(chan_out), .o_credit(o_credit));

// File: sim/pid_dispatch_tb.sv
module pid_dispatch_tb;
   timeunit 1ns;
   timeprecision 1ps;

   localparam int N_SRC = 8;
   localparam int N_CHAN = 8;
   localparam int DATA_W = 18;
   localparam int FIFO_DEPTH = 4;
   localparam int OUT_CREDITS = 2;
   localparam int TIMEOUT = 300;

   logic clk_in;
   logic reset;
   logic s_valid;
   logic s_credit;
   logic cfg_wr;
   logic dv_out;
   logic stall;
   logic o_credit = 1'b0;
   logic [dispatch_pkg::SRC_IDX_W-1:0] s_src;
   logic [dispatch_pkg::CFG_ADDR_W-1:0] cfg_addr;
   logic [dispatch_pkg::CHAN_IDX_W-1:0] cfg_chan;
   logic [dispatch_pkg::CHAN_IDX_W-1:0] chan_out;
   logic [DATA_W-1:0] s_data;
   logic [DATA_W-1:0] data_out;
   logic [DATA_W-1:0] exp_d;
   dispatch_pkg::cfg_word_u cfg_data;

   // Route mirror where src -1 means no source
   logic ref_en [N_CHAN];
   int ref_sel [N_CHAN];
   int exp_chan_q[$];
   logic [DATA_W-1:0] exp_data_q[$];

   // Running counts
   int n_sent;
   int n_back;
   int n_dv;
   int exp_c;
   int seed;
   int mon_errors;
   int test_errors;
   int base_dv;
   int base_back;
   int lat;
   int owed = 0;

   pid_dispatch_top #(.N_SRC(N_SRC), .N_CHAN(N_CHAN), .DATA_W(DATA_W),
      .FIFO_DEPTH(FIFO_DEPTH), .OUT_CREDITS(OUT_CREDITS)) pid_dispatch_top_inst (
      .clk_in(clk_in), .reset(reset), .s_valid(s_valid), .s_src(s_src), .s_data(s_data),
      .s_credit(s_credit), .cfg_wr(cfg_wr), .cfg_addr(cfg_addr), .cfg_chan(cfg_chan),
      .cfg_data(cfg_data), .dv_out(dv_out), .chan_out(chan_out), .data_out(data_out),
      .o_credit(o_credit));

   initial begin
      clk_in = 1'b0;
      forever #10 clk_in = ~clk_in;
   end

   // Downstream pipeline returns one credit per retired instruction
   always @(posedge clk_in) begin
      if (reset) begin
         owed = 0;
         o_credit <= 1'b0;
      end else begin
         if (dv_out) begin
            owed = owed + 1;
         end
         if (!stall && owed > 0) begin
            o_credit <= 1'b1;
            owed = owed - 1;
         end else begin
            o_credit <= 1'b0;
         end
      end
   end

   // ------------------------------
   // Output monitor at mid-cycle
   // ------------------------------
   always @(negedge clk_in) begin
      if (s_credit) begin
         n_back++;
      end
      if (dv_out) begin
         // Every instruction counts, expected or not
         n_dv++;
         assert (exp_chan_q.size() != 0) else begin
            mon_errors++;
            $display("Unexpected instruction on channel %0d at %0t", chan_out, $time);
         end
         if (exp_chan_q.size() != 0) begin
            exp_c = exp_chan_q.pop_front();
            exp_d = exp_data_q.pop_front();
            assert (32'(chan_out) == exp_c) else begin
               mon_errors++;
               $display("CHECK FAILED at %0t: chan_out expected %0d, got %0d",
                        $time, exp_c, chan_out);
            end
            assert (data_out == exp_d) else begin
               mon_errors++;
               $display("CHECK FAILED at %0t: data_out expected %0h, got %0h",
                        $time, exp_d, data_out);
            end
         end
      end
   end

   task automatic check_value(input string name, input int expected, input int actual);
      assert (expected == actual) else begin
         test_errors++;
         $display("CHECK FAILED at %0t: %s expected %0d, got %0d", $time, name, expected, actual);
      end
   endtask

   task automatic write_cfg(input logic [3:0] addr, input int chan, input logic [7:0] word);
      @(posedge clk_in);
      cfg_wr <= 1'b1;
      cfg_addr <= addr;
      cfg_chan <= 5'(chan);
      cfg_data <= word;
      @(posedge clk_in);
      cfg_wr <= 1'b0;
   endtask

   // Out-of-range channels leave the mirror alone
   task automatic set_enable(input int chan, input logic en);
      write_cfg(dispatch_pkg::CFG_ADDR_ENABLE, chan, {7'b0, en});
      if (chan < N_CHAN) ref_en[chan] = en;
   endtask

   task automatic set_route(input int chan, input int src);
      write_cfg(dispatch_pkg::CFG_ADDR_ROUTE, chan,
                (src < 0) ? {2'b00, 1'b1, 5'b0} : {2'b00, 1'b0, 5'(src)});
      if (chan < N_CHAN) ref_sel[chan] = src;
   endtask

   // One sample per upstream credit with its expected channels in ascending order
   task automatic send_sample(input int src);
      int waited;
      logic [DATA_W-1:0] d;
      waited = 0;
      // Line goes idle while the sender has no credit
      if (n_sent - n_back >= FIFO_DEPTH) begin
         @(posedge clk_in);
         s_valid <= 1'b0;
      end
      while (n_sent - n_back >= FIFO_DEPTH && waited < TIMEOUT) begin
         @(negedge clk_in);
         waited++;
      end
      if (waited >= TIMEOUT) begin
         test_errors++;
         $display("Timed out waiting for an input credit");
      end else begin
         d = DATA_W'($random(seed));
         @(posedge clk_in);
         s_valid <= 1'b1;
         s_src <= 5'(src);
         s_data <= d;
         n_sent++;
         for (int c = 0; c < N_CHAN; c++) begin
            if (ref_en[c] && ref_sel[c] == src) begin
               exp_chan_q.push_back(c);
               exp_data_q.push_back(d);
            end
         end
      end
   endtask

   task automatic end_input();
      @(posedge clk_in);
      s_valid <= 1'b0;
   endtask

   task automatic drain_outputs();
      int waited;
      waited = 0;
      while ((exp_chan_q.size() != 0 || n_back != n_sent) && waited < TIMEOUT) begin
         @(negedge clk_in);
         waited++;
      end
      if (waited >= TIMEOUT) begin
         test_errors++;
         $display("Timed out draining, %0d instructions still missing", exp_chan_q.size());
      end
      // Quiet window catches stray instructions and credits
      repeat (4) @(negedge clk_in);
      check_value("s_credit count", n_sent, n_back);
   endtask

   // ------------------------------
   // Directed tests
   // ------------------------------
   task automatic no_route_silence();
      base_dv = n_dv;
      send_sample(1);
      send_sample(2);
      send_sample(7);
      end_input();
      drain_outputs();
      check_value("dv_out count", 0, n_dv - base_dv);
   endtask

   task automatic single_route_latency();
      set_route(5, 2);
      set_enable(5, 1'b1);
      base_dv = n_dv;
      send_sample(2);
      end_input();
      lat = 0;
      while (!dv_out && lat < TIMEOUT) begin
         @(negedge clk_in);
         lat++;
      end
      if (lat >= TIMEOUT) begin
         test_errors++;
         $display("Timed out waiting for the first instruction");
      end else begin
         check_value("dv_out latency", 2, lat);
      end
      drain_outputs();
      check_value("dv_out count", 1, n_dv - base_dv);
   endtask

   task automatic fanout_order();
      set_route(1, 4);
      set_route(3, 4);
      set_route(6, 4);
      set_route(0, 4);
      set_enable(1, 1'b1);
      set_enable(3, 1'b1);
      set_enable(6, 1'b1);
      base_dv = n_dv;
      send_sample(4);
      send_sample(2);
      send_sample(4);
      end_input();
      drain_outputs();
      check_value("dv_out count", 7, n_dv - base_dv);
   endtask

   task automatic reconfig_effects();
      set_enable(3, 1'b0);
      set_route(6, 2);
      set_route(2, 4);
      set_enable(2, 1'b1);
      set_route(2, -1);
      set_enable(8, 1'b1);
      set_route(13, 4);
      base_dv = n_dv;
      send_sample(4);
      send_sample(2);
      end_input();
      drain_outputs();
      check_value("dv_out count", 3, n_dv - base_dv);
   endtask

   task automatic backpressure_hold();
      set_route(7, 2);
      set_enable(7, 1'b1);
      set_route(0, 2);
      set_enable(0, 1'b1);
      @(posedge clk_in);
      stall <= 1'b1;
      base_dv = n_dv;
      base_back = n_back;
      repeat (FIFO_DEPTH) send_sample(2);
      end_input();
      repeat (20) @(negedge clk_in);
      check_value("dv_out while stalled", OUT_CREDITS, n_dv - base_dv);
      check_value("s_credit while stalled", 0, n_back - base_back);
      @(posedge clk_in);
      stall <= 1'b0;
      drain_outputs();
      check_value("dv_out count", 4 * FIFO_DEPTH, n_dv - base_dv);
   endtask

   initial begin
      seed = 32'h96e0;
      reset = 1'b1;
      stall = 1'b0;
      s_valid = 1'b0;
      s_src = '0;
      s_data = '0;
      cfg_wr = 1'b0;
      cfg_addr = '0;
      cfg_chan = '0;
      cfg_data = '0;
      for (int c = 0; c < N_CHAN; c++) begin
         ref_en[c] = 1'b0;
         ref_sel[c] = -1;
      end
      repeat (5) @(posedge clk_in);
      reset <= 1'b0;
      no_route_silence();
      single_route_latency();
      fanout_order();
      reconfig_effects();
      backpressure_hold();
      $display("Errors: %0d from monitor, %0d from tests", mon_errors, test_errors);
      if (mon_errors + test_errors == 0) begin
         $display("** PASS **");
      end else begin
         $display("** FAIL **");
      end
      $finish;
   end

endmodule
